// File: design/axi_image_reader.sv
/* AXI read master fetching the image in bursts into the image store */
module axi_image_reader #(
	parameter int BURST_LEN = 16
) (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   go,
	output logic                                   done,
	input  logic [glcm_pkg::ADDR_W-1:0]            img_addr,
	output glcm_pkg::axi_rd_req_t                  rd_req,
	input  glcm_pkg::axi_rd_rsp_t                  rd_rsp,
	output logic                                   img_we,
	output logic [$clog2(glcm_pkg::IMG_WORDS)-1:0] img_idx,
	output logic [glcm_pkg::DATA_W-1:0]            img_word
);
	import glcm_pkg::*;

	localparam int                IDX_W       = $clog2(IMG_WORDS);
	localparam logic [ADDR_W-1:0] BURST_BYTES = ADDR_W'(BURST_LEN * BYTES_PER_WORD);

	typedef enum logic [1:0] {ST_IDLE, ST_ADDR, ST_DATA, ST_DONE} state_t;

	state_t            state;
	logic [ADDR_W-1:0] araddr_q;
	logic              beat;
	logic              last_word;

	assign beat      = (state == ST_DATA) && rd_rsp.rvalid;
	assign last_word = (img_idx == IDX_W'(IMG_WORDS - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= ST_IDLE;
			img_idx <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (go) begin
						state   <= ST_ADDR;
						img_idx <= '0;
					end
				end
				ST_ADDR: begin
					if (rd_rsp.arready)
						state <= ST_DATA;
				end
				ST_DATA: begin
					if (beat) begin
						img_idx <= img_idx + 1'b1;
						// End of burst, either next address or finished
						if (rd_rsp.rlast)
							state <= last_word ? ST_DONE : ST_ADDR;
					end
				end
				ST_DONE: begin
					if (!go)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Each burst starts BURST_LEN words past the previous one
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && go)
			araddr_q <= img_addr;
		else if (beat && rd_rsp.rlast)
			araddr_q <= araddr_q + BURST_BYTES;
	end

	always_comb begin
		rd_req.araddr  = araddr_q;
		rd_req.arvalid = (state == ST_ADDR);
		rd_req.rready  = (state == ST_DATA);
	end

	// Beats go straight into the store
	assign img_we   = beat;
	assign img_word = rd_rsp.rdata;
	assign done     = (state == ST_DONE);

endmodule

// File: design/axi_result_writer.sv
/* AXI write master streaming matrix words out in bursts */
module axi_result_writer #(
	parameter int BURST_LEN = 16
) (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   go,
	output logic                                   done,
	input  logic [glcm_pkg::ADDR_W-1:0]            res_addr,
	output glcm_pkg::axi_wr_req_t                  wr_req,
	input  glcm_pkg::axi_wr_rsp_t                  wr_rsp,
	output logic [$clog2(glcm_pkg::RES_WORDS)-1:0] res_idx,
	input  logic [glcm_pkg::DATA_W-1:0]            res_word
);
	import glcm_pkg::*;

	localparam int                IDX_W       = $clog2(RES_WORDS);
	localparam logic [ADDR_W-1:0] BURST_BYTES = ADDR_W'(BURST_LEN * BYTES_PER_WORD);

	typedef enum logic [2:0] {ST_IDLE, ST_AW, ST_W, ST_B, ST_DONE} state_t;

	state_t            state;
	logic [ADDR_W-1:0] awaddr_q;
	logic              final_q;
	logic              beat;
	logic              wlast;

	assign beat  = (state == ST_W) && wr_rsp.wready;
	// Bursts are aligned on the word index
	assign wlast = ((int'(res_idx) % BURST_LEN) == BURST_LEN - 1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= ST_IDLE;
			res_idx <= '0;
			final_q <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (go) begin
						state   <= ST_AW;
						res_idx <= '0;
						final_q <= 1'b0;
					end
				end
				ST_AW: begin
					if (wr_rsp.awready)
						state <= ST_W;
				end
				ST_W: begin
					if (beat) begin
						res_idx <= res_idx + 1'b1;
						if (res_idx == IDX_W'(RES_WORDS - 1))
							final_q <= 1'b1;
						if (wlast)
							state <= ST_B;
					end
				end
				ST_B: begin
					// Next address only once the response is in
					if (wr_rsp.bvalid)
						state <= final_q ? ST_DONE : ST_AW;
				end
				ST_DONE: begin
					if (!go)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && go)
			awaddr_q <= res_addr;
		else if (state == ST_B && wr_rsp.bvalid)
			awaddr_q <= awaddr_q + BURST_BYTES;
	end

	// wdata follows res_idx, so it holds while wready is low
	always_comb begin
		wr_req.awaddr  = awaddr_q;
		wr_req.awvalid = (state == ST_AW);
		wr_req.wdata   = res_word;
		wr_req.wlast   = wlast;
		wr_req.wvalid  = (state == ST_W);
		wr_req.bready  = (state == ST_B);
	end

	assign done = (state == ST_DONE);

endmodule

// File: design/glcm_accumulator.sv
/* Image store, two-stage pair pipeline with bounds rule,
   32x32 counter matrix and its word read port */
module glcm_accumulator (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   go,
	output logic                                   done,
	input  glcm_pkg::dir_t                         dir,
	input  logic [3:0]                             dis,
	input  logic                                   img_we,
	input  logic [$clog2(glcm_pkg::IMG_WORDS)-1:0] img_idx,
	input  logic [glcm_pkg::DATA_W-1:0]            img_word,
	input  logic [$clog2(glcm_pkg::RES_WORDS)-1:0] res_idx,
	output logic [glcm_pkg::DATA_W-1:0]            res_word
);
	import glcm_pkg::*;

	localparam int PIXELS    = IMG_DIM * IMG_DIM;
	localparam int PIX_IDX_W = $clog2(PIXELS);
	localparam int POS_W     = $clog2(IMG_DIM);
	localparam int BYTE_W    = DATA_W / BYTES_PER_WORD;
	localparam int BSEL_W    = $clog2(BYTES_PER_WORD);
	localparam int GL_W      = $clog2(GRAY_LEVELS);
	localparam int WSEL_W    = $clog2(GRAY_LEVELS / BYTES_PER_WORD);
	// Origins issue on steps 0..PIXELS-1, last increment one step later
	localparam int LAST_STEP = PIXELS + 1;

	typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_DONE} state_t;

	state_t             state;
	logic [PIX_IDX_W:0] step;
	logic [DATA_W-1:0]  img_mem [IMG_WORDS];
	logic [CNT_W-1:0]   glcm_mem [GRAY_LEVELS][GRAY_LEVELS];

	logic [PIX_IDX_W-1:0] org_idx;
	logic [PIX_IDX_W-1:0] off_idx;
	logic [POS_W:0]       row_end;
	logic [POS_W:0]       col_end;
	logic                 in_bounds;
	logic                 issue;

	// Fetched pair
	logic             s1_inc;
	logic [PIX_W-1:0] s1_org;
	logic [PIX_W-1:0] s1_off;

	function automatic logic [PIX_W-1:0] pix_at(input logic [PIX_IDX_W-1:0] idx);
		logic [DATA_W-1:0] word;
		word = img_mem[idx[PIX_IDX_W-1:BSEL_W]];
		return word[idx[BSEL_W-1:0] * BYTE_W +: PIX_W];
	endfunction

	always_ff @(posedge clk) begin
		if (img_we)
			img_mem[img_idx] <= img_word;
	end

	// ------------------------------
	// Offset pixel and bounds rule
	always_comb begin
		org_idx = step[PIX_IDX_W-1:0];
		row_end = (POS_W+1)'(org_idx[PIX_IDX_W-1 -: POS_W]) + (POS_W+1)'(dis);
		col_end = (POS_W+1)'(org_idx[POS_W-1:0]) + (POS_W+1)'(dis);
		case (dir)
			VERT: begin
				off_idx   = org_idx + PIX_IDX_W'(dis * IMG_DIM);
				in_bounds = (row_end < IMG_DIM);
			end
			HORZ: begin
				off_idx   = org_idx + PIX_IDX_W'(dis);
				in_bounds = (col_end < IMG_DIM);
			end
			DIAG: begin
				off_idx   = org_idx + PIX_IDX_W'(dis * (IMG_DIM + 1));
				in_bounds = (row_end < IMG_DIM) && (col_end < IMG_DIM);
			end
			default: begin
				// NONE counts nothing
				off_idx   = org_idx;
				in_bounds = 1'b0;
			end
		endcase
	end

	assign issue = (state == ST_RUN) && (step < PIXELS);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= ST_IDLE;
			step   <= '0;
			s1_inc <= 1'b0;
		end else begin
			s1_inc <= issue && in_bounds;
			case (state)
				ST_IDLE: begin
					if (go) begin
						state <= ST_RUN;
						step  <= '0;
					end
				end
				ST_RUN: begin
					if (step == LAST_STEP)
						state <= ST_DONE;
					else
						step <= step + 1'b1;
				end
				ST_DONE: begin
					if (!go)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			s1_org <= pix_at(org_idx);
			s1_off <= pix_at(off_idx);
		end
	end

	// ------------------------------
	// Counter matrix, cleared on go
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && go) begin
			for (int i = 0; i < GRAY_LEVELS; i++) begin
				for (int j = 0; j < GRAY_LEVELS; j++) begin
					glcm_mem[i][j] <= '0;
				end
			end
		end else if (s1_inc) begin
			glcm_mem[s1_org][s1_off] <= glcm_mem[s1_org][s1_off] + 1'b1;
		end
	end

	// Row from the upper index bits, lowest column in the lowest byte
	always_comb begin
		for (int b = 0; b < BYTES_PER_WORD; b++) begin
			res_word[b*CNT_W +: CNT_W] =
				glcm_mem[res_idx[WSEL_W +: GL_W]][{res_idx[WSEL_W-1:0], BSEL_W'(b)}];
		end
	end

	assign done = (state == ST_DONE);

endmodule

// File: design/glcm_ctrl.sv
/* Command latch and READ, COUNT, WRITE sequencer with out_valid pulse */
module glcm_ctrl (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_valid,
	input  glcm_pkg::glcm_cmd_t in_cmd,
	output logic                out_valid,
	output glcm_pkg::glcm_cmd_t cmd,
	output logic                rd_go,
	input  logic                rd_done,
	output logic                acc_go,
	input  logic                acc_done,
	output logic                wr_go,
	input  logic                wr_done
);

	// REQ holds go high, REL waits for done to drop
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_RD_REQ,
		ST_RD_REL,
		ST_ACC_REQ,
		ST_ACC_REL,
		ST_WR_REQ,
		ST_WR_REL
	} state_t;

	state_t state;
	state_t state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE:    if (in_valid) state_nxt = ST_RD_REQ;
			ST_RD_REQ:  if (rd_done) state_nxt = ST_RD_REL;
			ST_RD_REL:  if (!rd_done) state_nxt = ST_ACC_REQ;
			ST_ACC_REQ: if (acc_done) state_nxt = ST_ACC_REL;
			ST_ACC_REL: if (!acc_done) state_nxt = ST_WR_REQ;
			ST_WR_REQ:  if (wr_done) state_nxt = ST_WR_REL;
			ST_WR_REL:  if (!wr_done) state_nxt = ST_IDLE;
			default:    state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= ST_IDLE;
			out_valid <= 1'b0;
		end else begin
			state     <= state_nxt;
			// Writer handshake closed, job complete
			out_valid <= (state == ST_WR_REL) && !wr_done;
		end
	end

	// Commands arriving while busy are dropped
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && in_valid)
			cmd <= in_cmd;
	end

	assign rd_go  = (state == ST_RD_REQ);
	assign acc_go = (state == ST_ACC_REQ);
	assign wr_go  = (state == ST_WR_REQ);

endmodule

// File: design/glcm_pkg.sv
/* Widths, sizes, direction encoding and the packed structs
   for the command and the AXI read and write channels */
package glcm_pkg;

	localparam int ADDR_W         = 32;
	localparam int DATA_W         = 32;
	localparam int IMG_DIM        = 16;
	localparam int PIX_W          = 5;
	localparam int CNT_W          = 8;
	localparam int GRAY_LEVELS    = 32;
	localparam int BYTES_PER_WORD = 4;
	// Four pixels or four counters per bus word
	localparam int IMG_WORDS      = IMG_DIM * IMG_DIM / BYTES_PER_WORD;
	localparam int RES_WORDS      = GRAY_LEVELS * GRAY_LEVELS / BYTES_PER_WORD;

	typedef enum logic [1:0] {
		NONE = 2'd0,
		VERT = 2'd1,
		HORZ = 2'd2,
		DIAG = 2'd3
	} dir_t;

	typedef struct packed {
		logic [ADDR_W-1:0] img_addr;
		logic [ADDR_W-1:0] res_addr;
		dir_t              dir;
		logic [3:0]        dis;
	} glcm_cmd_t;

	// ------------------------------
	// AXI channels, master view
	typedef struct packed {
		logic [ADDR_W-1:0] araddr;
		logic              arvalid;
		logic              rready;
	} axi_rd_req_t;

	typedef struct packed {
		logic              arready;
		logic [DATA_W-1:0] rdata;
		logic              rlast;
		logic              rvalid;
	} axi_rd_rsp_t;

	typedef struct packed {
		logic [ADDR_W-1:0] awaddr;
		logic              awvalid;
		logic [DATA_W-1:0] wdata;
		logic              wlast;
		logic              wvalid;
		logic              bready;
	} axi_wr_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
	} axi_wr_rsp_t;

endpackage

// File: design/glcm_top.sv
/* GLCM engine top level, wiring the controller, image reader,
   accumulator and result writer */
module glcm_top #(
	parameter int BURST_LEN = 16
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  glcm_pkg::glcm_cmd_t   in_cmd,
	output logic                  out_valid,
	output glcm_pkg::axi_rd_req_t rd_req,
	input  glcm_pkg::axi_rd_rsp_t rd_rsp,
	output glcm_pkg::axi_wr_req_t wr_req,
	input  glcm_pkg::axi_wr_rsp_t wr_rsp
);
	import glcm_pkg::*;

	glcm_cmd_t cmd;

	// Four-phase pairs to each block
	logic rd_go, rd_done;
	logic acc_go, acc_done;
	logic wr_go, wr_done;

	// Image store write port and matrix read port
	logic                         img_we;
	logic [$clog2(IMG_WORDS)-1:0] img_idx;
	logic [DATA_W-1:0]            img_word;
	logic [$clog2(RES_WORDS)-1:0] res_idx;
	logic [DATA_W-1:0]            res_word;

	glcm_ctrl ctrl0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_cmd   (in_cmd),
		.out_valid(out_valid),
		.cmd      (cmd),
		.rd_go    (rd_go),
		.rd_done  (rd_done),
		.acc_go   (acc_go),
		.acc_done (acc_done),
		.wr_go    (wr_go),
		.wr_done  (wr_done)
	);

	axi_image_reader #(
		.BURST_LEN(BURST_LEN)
	) rdr0 (
		.clk     (clk),
		.rst_n   (rst_n),
		.go      (rd_go),
		.done    (rd_done),
		.img_addr(cmd.img_addr),
		.rd_req  (rd_req),
		.rd_rsp  (rd_rsp),
		.img_we  (img_we),
		.img_idx (img_idx),
		.img_word(img_word)
	);

	glcm_accumulator acc0 (
		.clk     (clk),
		.rst_n   (rst_n),
		.go      (acc_go),
		.done    (acc_done),
		.dir     (cmd.dir),
		.dis     (cmd.dis),
		.img_we  (img_we),
		.img_idx (img_idx),
		.img_word(img_word),
		.res_idx (res_idx),
		.res_word(res_word)
	);

	axi_result_writer #(
		.BURST_LEN(BURST_LEN)
	) wrt0 (
		.clk     (clk),
		.rst_n   (rst_n),
		.go      (wr_go),
		.done    (wr_done),
		.res_addr(cmd.res_addr),
		.wr_req  (wr_req),
		.wr_rsp  (wr_rsp),
		.res_idx (res_idx),
		.res_word(res_word)
	);

endmodule

// File: glcm.f
design/glcm_pkg.sv
design/glcm_ctrl.sv
design/axi_image_reader.sv
design/glcm_accumulator.sv
design/axi_result_writer.sv
design/glcm_top.sv
testbench/glcm_dram_model.sv
testbench/glcm_assert.sv
testbench/glcm_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator and run; passes only if the pass message is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f glcm.f --top-module glcm_tb -Mdir obj_dir \
	&& ./obj_dir/Vglcm_tb | tee /dev/stderr | grep -q "Simulation finished: PASS" \
	&& echo "run_sim: passed" \
	|| { echo "run_sim: failed"; exit 1; }

// File: testbench/glcm_assert.sv
/* Protocol and timing checks, bound to the GLCM top level */
module glcm_assert (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  out_valid,
	input glcm_pkg::axi_rd_req_t rd_req,
	input glcm_pkg::axi_rd_rsp_t rd_rsp,
	input glcm_pkg::axi_wr_req_t wr_req,
	input glcm_pkg::axi_wr_rsp_t wr_rsp
);
	timeunit 1ns;
	timeprecision 100ps;

	logic fail_seen = 1'b0;

	logic quiet;
	assign quiet = !out_valid && !rd_req.arvalid && !rd_req.rready &&
		!wr_req.awvalid && !wr_req.wvalid && !wr_req.bready;

	reset_quiet: assert property (@(posedge clk) !rst_n || $rose(rst_n) |-> quiet)
		else begin
			$error("Outputs not low during or right after reset");
			fail_seen = 1'b1;
		end

	ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
		rd_req.arvalid && !rd_rsp.arready |=> rd_req.arvalid && $stable(rd_req.araddr))
		else begin
			$error("araddr or arvalid changed while waiting for arready");
			fail_seen = 1'b1;
		end

	aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
		wr_req.awvalid && !wr_rsp.awready |=> wr_req.awvalid && $stable(wr_req.awaddr))
		else begin
			$error("awaddr or awvalid changed while waiting for awready");
			fail_seen = 1'b1;
		end

	// Write data held under back-pressure
	w_stable: assert property (@(posedge clk) disable iff (!rst_n)
		wr_req.wvalid && !wr_rsp.wready |=>
			wr_req.wvalid && $stable(wr_req.wdata) && $stable(wr_req.wlast))
		else begin
			$error("wdata or wlast changed while waiting for wready");
			fail_seen = 1'b1;
		end

	done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |=> !out_valid)
		else begin
			$error("out_valid high for more than one cycle");
			fail_seen = 1'b1;
		end

endmodule

bind glcm_top glcm_assert chk0 (
	.clk      (clk),
	.rst_n    (rst_n),
	.out_valid(out_valid),
	.rd_req   (rd_req),
	.rd_rsp   (rd_rsp),
	.wr_req   (wr_req),
	.wr_rsp   (wr_rsp)
);

// File: testbench/glcm_dram_model.sv
/* AXI memory model with random ready delays, image fill
   and checking of written result words */
module glcm_dram_model #(
	parameter int BURST_LEN = 16
) (
	input  logic                  clk,
	input  glcm_pkg::axi_rd_req_t rd_req,
	output glcm_pkg::axi_rd_rsp_t rd_rsp,
	input  glcm_pkg::axi_wr_req_t wr_req,
	output glcm_pkg::axi_wr_rsp_t wr_rsp,
	output logic                  error_seen
);
	timeunit 1ns;
	timeprecision 100ps;
	import glcm_pkg::*;

	logic [DATA_W-1:0] mem [int unsigned];
	logic [DATA_W-1:0] expect_mem [int unsigned];
	logic [ADDR_W-1:0] img_base;
	logic [ADDR_W-1:0] res_base;
	int                rd_bursts;
	int                wr_bursts;
	int                wr_words;
	string             test_name;

	initial void'($urandom(32'hdc83af32));
	initial error_seen = 1'b0;

	// Model outputs change 2 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic stall();
		repeat ($urandom_range(0, 3)) next_cycle();
	endtask

	task automatic report(input string what, input logic [31:0] exp, input logic [31:0] act);
		$display("Mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
		error_seen = 1'b1;
	endtask

	task automatic load_image(input logic [ADDR_W-1:0] base, input bit flat,
			input logic [7:0] value);
		for (int w = 0; w < IMG_WORDS; w++) begin
			mem[32'((base >> 2) + w)] = flat ? {4{value}} : $urandom();
		end
	endtask

	task automatic start_job(input string name, input logic [ADDR_W-1:0] img,
			input logic [ADDR_W-1:0] res);
		test_name = name;
		img_base  = img;
		res_base  = res;
		rd_bursts = 0;
		wr_bursts = 0;
		wr_words  = 0;
		expect_mem.delete();
	endtask

	function automatic logic [DATA_W-1:0] read_word(input int unsigned wa);
		return mem.exists(wa) ? mem[wa] : '0;
	endfunction

	// ------------------------------
	// Read channel
	initial begin
		logic [ADDR_W-1:0] addr;
		rd_rsp = '0;
		forever begin
			next_cycle();
			if (rd_req.arvalid) begin
				addr = rd_req.araddr;
				stall();
				rd_rsp.arready = 1'b1;
				next_cycle();
				rd_rsp.arready = 1'b0;
				if (addr !== ADDR_W'(img_base + rd_bursts * BURST_LEN * BYTES_PER_WORD))
					report("read address",
						ADDR_W'(img_base + rd_bursts * BURST_LEN * BYTES_PER_WORD), addr);
				rd_bursts++;
				for (int j = 0; j < BURST_LEN; j++) begin
					stall();
					rd_rsp.rvalid = 1'b1;
					rd_rsp.rdata  = read_word(32'((addr >> 2) + j));
					rd_rsp.rlast  = (j == BURST_LEN - 1);
					if (rd_req.rready !== 1'b1) begin
						$display("In %s rready is low while a read beat is offered", test_name);
						error_seen = 1'b1;
					end
					next_cycle();
					rd_rsp.rvalid = 1'b0;
					rd_rsp.rlast  = 1'b0;
				end
			end
		end
	end

	// ------------------------------
	// Write channel, words compared as they are accepted
	initial begin
		logic [ADDR_W-1:0] addr;
		int unsigned       wa;
		wr_rsp = '0;
		forever begin
			next_cycle();
			if (wr_req.awvalid) begin
				addr = wr_req.awaddr;
				stall();
				wr_rsp.awready = 1'b1;
				next_cycle();
				wr_rsp.awready = 1'b0;
				if (addr !== ADDR_W'(res_base + wr_bursts * BURST_LEN * BYTES_PER_WORD))
					report("write address",
						ADDR_W'(res_base + wr_bursts * BURST_LEN * BYTES_PER_WORD), addr);
				wr_bursts++;
				for (int j = 0; j < BURST_LEN; j++) begin
					stall();
					wr_rsp.wready = 1'b1;
					wa = 32'((addr >> 2) + j);
					if (wr_req.wvalid !== 1'b1) begin
						$display("In %s wvalid is low while a write beat is due", test_name);
						error_seen = 1'b1;
					end
					if (wr_req.wlast !== (j == BURST_LEN - 1))
						report("wlast", 32'(j == BURST_LEN - 1), 32'(wr_req.wlast));
					if (!expect_mem.exists(wa)) begin
						$display("Write to word address %h lies outside the result area", wa);
						error_seen = 1'b1;
					end else if (wr_req.wdata !== expect_mem[wa]) begin
						report("result word", expect_mem[wa], wr_req.wdata);
					end
					wr_words++;
					next_cycle();
					wr_rsp.wready = 1'b0;
				end
				stall();
				wr_rsp.bvalid = 1'b1;
				if (wr_req.bready !== 1'b1) begin
					$display("In %s bready is low while a write response is offered",
						test_name);
					error_seen = 1'b1;
				end
				next_cycle();
				wr_rsp.bvalid = 1'b0;
			end
		end
	end

endmodule

// File: testbench/glcm_tb.sv
/* Testbench top with clock, reset, command sequence,
   reference GLCM model and timeout */
module glcm_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import glcm_pkg::*;

	localparam int BURST_LEN   = 16;
	localparam int CYCLE_LIMIT = 6 * 2000;

	logic        clk;
	logic        rst_n;
	logic        in_valid;
	logic        out_valid;
	logic        dram_error;
	glcm_cmd_t   in_cmd;
	axi_rd_req_t rd_req;
	axi_rd_rsp_t rd_rsp;
	axi_wr_req_t wr_req;
	axi_wr_rsp_t wr_rsp;
	int          cycles = 0;

	glcm_top #(
		.BURST_LEN(BURST_LEN)
	) dut0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_cmd   (in_cmd),
		.out_valid(out_valid),
		.rd_req   (rd_req),
		.rd_rsp   (rd_rsp),
		.wr_req   (wr_req),
		.wr_rsp   (wr_rsp)
	);

	glcm_dram_model #(
		.BURST_LEN(BURST_LEN)
	) dram0 (
		.clk       (clk),
		.rd_req    (rd_req),
		.rd_rsp    (rd_rsp),
		.wr_req    (wr_req),
		.wr_rsp    (wr_rsp),
		.error_seen(dram_error)
	);

	always #20 clk = ~clk;

	// Stop at the first error or at the cycle limit
	always @(posedge clk) begin
		cycles++;
		if (dram_error || dut0.chk0.fail_seen) begin
			$display("Simulation finished: FAIL");
			$fatal(1, "Stopped at the first error");
		end else if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: no result after %0d cycles", cycles);
			$display("Simulation finished: FAIL");
			$fatal(1, "Run exceeded its cycle limit");
		end
	end

	task automatic count_mismatch(input string name, input string what, input int exp,
			input int act);
		$display("Mismatch %s %s: expected %0d actual %0d", name, what, exp, act);
		$display("Simulation finished: FAIL");
		$fatal(1, "Stopped at the first error");
	endtask

	function automatic logic [PIX_W-1:0] pixel(input logic [ADDR_W-1:0] base, input int p);
		logic [DATA_W-1:0] word;
		word = dram0.mem[32'((base >> 2) + p / 4)];
		return word[8 * (p % 4) +: PIX_W];
	endfunction

	// ------------------------------
	// Reference matrix from the counting rule
	task automatic build_reference(input glcm_cmd_t cmd);
		int                cnt [GRAY_LEVELS][GRAY_LEVELS];
		int                dr;
		int                dc;
		logic [DATA_W-1:0] word;
		cnt = '{default: '{default: 0}};
		dr  = (cmd.dir == VERT || cmd.dir == DIAG) ? int'(cmd.dis) : 0;
		dc  = (cmd.dir == HORZ || cmd.dir == DIAG) ? int'(cmd.dis) : 0;
		if (cmd.dir != NONE) begin
			for (int p = 0; p < IMG_DIM * IMG_DIM; p++) begin
				if (p / IMG_DIM + dr < IMG_DIM && p % IMG_DIM + dc < IMG_DIM)
					cnt[pixel(cmd.img_addr, p)][pixel(cmd.img_addr, p + IMG_DIM * dr + dc)]++;
			end
		end
		for (int w = 0; w < RES_WORDS; w++) begin
			for (int b = 0; b < BYTES_PER_WORD; b++) begin
				word[8 * b +: 8] = 8'(cnt[w / 8][4 * (w % 8) + b]);
			end
			dram0.expect_mem[32'((cmd.res_addr >> 2) + w)] = word;
		end
	endtask

	task automatic run_test(input string name, input dir_t dir, input logic [3:0] dis,
			input bit flat);
		glcm_cmd_t cmd;
		cmd.img_addr = 32'h1000_0000 + 32'($urandom_range(0, 255)) * 32'd256;
		cmd.res_addr = 32'h2000_0000 + 32'($urandom_range(0, 255)) * 32'd1024;
		cmd.dir      = dir;
		cmd.dis      = dis;
		dram0.load_image(cmd.img_addr, flat, 8'($urandom()));
		dram0.start_job(name, cmd.img_addr, cmd.res_addr);
		build_reference(cmd);
		in_cmd   = cmd;
		in_valid = 1'b1;
		@(posedge clk);
		#2;
		in_valid = 1'b0;
		do begin
			@(posedge clk);
			#1;
		end while (!out_valid);
		#1;
		if (dram0.rd_bursts != IMG_WORDS / BURST_LEN)
			count_mismatch(name, "read bursts", IMG_WORDS / BURST_LEN, dram0.rd_bursts);
		if (dram0.wr_words != RES_WORDS)
			count_mismatch(name, "written words", RES_WORDS, dram0.wr_words);
	endtask

	initial begin
		clk      = 1'b0;
		rst_n    = 1'b0;
		in_valid = 1'b0;
		in_cmd   = '0;
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
		// Commands follow each other back to back
		run_test("horz_random", HORZ, 4'($urandom_range(1, 15)), 1'b0);
		run_test("vert_random", VERT, 4'($urandom_range(1, 15)), 1'b0);
		run_test("horz_far", HORZ, 4'd14, 1'b0);
		run_test("diag_random", DIAG, 4'($urandom_range(1, 15)), 1'b0);
		run_test("dir_none", NONE, 4'($urandom_range(0, 15)), 1'b0);
		run_test("count_wrap", HORZ, 4'd0, 1'b1);
		if (dram_error || dut0.chk0.fail_seen) begin
			$display("Simulation finished: FAIL");
			$fatal(1, "Errors were seen during the run");
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule
